/* source/rv_core_cfg.svh */
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// Data path width
`define XLEN      32

// Architectural registers, x0 included
`define NUM_REGS  32
`define REG_AW    5     // Register index width

// One quotient bit per cycle
`define DIV_STEPS 32

`endif

/* source/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

	// Major opcodes the decoder accepts
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,	// Register-register, M extension too
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_SLL    = 4'd2,
		ALU_SLT    = 4'd3,
		ALU_SLTU   = 4'd4,
		ALU_XOR    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_OR     = 4'd8,
		ALU_AND    = 4'd9,
		ALU_PASS_B = 4'd10		// LUI immediate straight through
	} alu_op_e;

	// Same as funct3[1:0] of the divide group
	typedef enum logic [1:0] {
		DIV_DIV  = 2'b00,
		DIV_DIVU = 2'b01,
		DIV_REM  = 2'b10,
		DIV_REMU = 2'b11
	} div_op_e;

	// Unit that owns the result of an instruction
	typedef enum logic {
		RES_ALU = 1'b0,
		RES_DIV = 1'b1
	} res_sel_e;

endpackage

`default_nettype wire

/* source/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_cfg.svh"

module instr_decoder (
	input  logic [`XLEN-1:0]        instr,
	output logic [`REG_AW-1:0]      rs1,
	output logic [`REG_AW-1:0]      rs2,
	output logic [`REG_AW-1:0]      rd,
	output logic [`XLEN-1:0]        imm,
	output logic                    use_imm,
	output rv_core_pkg::res_sel_e   res_sel,
	output rv_core_pkg::alu_op_e    alu_op,
	output rv_core_pkg::div_op_e    div_op,
	output logic                    writes_rd,
	output logic                    illegal
);
	rv_core_pkg::opcode_e opcode;
	logic [2:0]           funct3;
	logic [6:0]           funct7;
	logic [`XLEN-1:0]     imm_i;
	logic [`XLEN-1:0]     imm_u;

	// Base integer op from funct3, alt picks SUB or SRA
	function automatic rv_core_pkg::alu_op_e base_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
			3'b001:  return rv_core_pkg::ALU_SLL;
			3'b010:  return rv_core_pkg::ALU_SLT;
			3'b011:  return rv_core_pkg::ALU_SLTU;
			3'b100:  return rv_core_pkg::ALU_XOR;
			3'b101:  return alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
			3'b110:  return rv_core_pkg::ALU_OR;
			default: return rv_core_pkg::ALU_AND;
		endcase
	endfunction

	assign opcode = rv_core_pkg::opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign rd     = instr[11:7];
	assign imm_i  = {{(`XLEN-12){instr[31]}}, instr[31:20]};	// Sign extended
	assign imm_u  = {instr[31:12], 12'b0};

	assign writes_rd = !illegal && (rd != '0);	// Nothing retires to x0

	always_comb begin
		use_imm = 1'b0;
		res_sel = rv_core_pkg::RES_ALU;
		alu_op  = rv_core_pkg::ALU_ADD;
		div_op  = rv_core_pkg::div_op_e'(funct3[1:0]);
		imm     = imm_i;
		illegal = 1'b0;
		case (opcode)
			rv_core_pkg::OPC_OP: begin
				if (funct7 == 7'b0000001) begin
					res_sel = rv_core_pkg::RES_DIV;
					illegal = !funct3[2];		// MUL group, no multiplier
				end else begin
					alu_op  = base_op(funct3, funct7[5]);
					// Only ADD/SUB and SRL/SRA have an alternate form
					illegal = (funct7 != 7'b0000000) &&
						!(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
				end
			end
			rv_core_pkg::OPC_OP_IMM: begin
				use_imm = 1'b1;
				alu_op  = base_op(funct3, (funct3 == 3'b101) && funct7[5]);	// No SUBI
				illegal = (funct3 == 3'b001 && funct7 != 7'b0000000) ||
					(funct3 == 3'b101 && funct7 != 7'b0000000 && funct7 != 7'b0100000);
			end
			rv_core_pkg::OPC_LUI: begin
				use_imm = 1'b1;
				imm     = imm_u;
				alu_op  = rv_core_pkg::ALU_PASS_B;
			end
			default: illegal = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

/* source/regfile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_cfg.svh"

module regfile (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  wr_en,
	input  logic [`REG_AW-1:0]    wr_addr,
	input  logic [`XLEN-1:0]      wr_data,
	input  logic [`REG_AW-1:0]    rd_addr_a,
	input  logic [`REG_AW-1:0]    rd_addr_b,
	output logic [`XLEN-1:0]      rd_data_a,
	output logic [`XLEN-1:0]      rd_data_b
);
	logic [`XLEN-1:0] regs [`NUM_REGS];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin	// x0 never written
			regs[wr_addr] <= wr_data;
		end
	end

	// Combinational read ports
	assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
	assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

`default_nettype wire

/* source/issue_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_cfg.svh"

module issue_stage (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    instr_valid,
	input  logic [`XLEN-1:0]        instr,
	input  logic                    div_busy,
	input  logic [`XLEN-1:0]        alu_result,
	input  logic                    wb_valid,
	input  logic [`REG_AW-1:0]      wb_rd,
	input  logic [`XLEN-1:0]        wb_data,
	output logic                    ex_valid,
	output rv_core_pkg::res_sel_e   ex_res_sel,
	output rv_core_pkg::alu_op_e    ex_alu_op,
	output rv_core_pkg::div_op_e    ex_div_op,
	output logic [`REG_AW-1:0]      ex_rd,
	output logic [`XLEN-1:0]        ex_op_a,
	output logic [`XLEN-1:0]        ex_op_b,
	output logic                    div_start
);
	logic [`REG_AW-1:0]    dec_rs1, dec_rs2, dec_rd;
	logic [`XLEN-1:0]      dec_imm;
	logic                  dec_use_imm, dec_writes_rd, dec_illegal;
	rv_core_pkg::res_sel_e dec_res_sel;
	rv_core_pkg::alu_op_e  dec_alu_op;
	rv_core_pkg::div_op_e  dec_div_op;
	logic [`XLEN-1:0]      rf_a, rf_b;
	logic [`XLEN-1:0]      op_a, op_b;
	logic                  ex_fwd;
	logic                  issue;

	instr_decoder decoder_i (
		.instr(instr), .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd),
		.imm(dec_imm), .use_imm(dec_use_imm), .res_sel(dec_res_sel),
		.alu_op(dec_alu_op), .div_op(dec_div_op),
		.writes_rd(dec_writes_rd), .illegal(dec_illegal)
	);

	// Written from writeback, read during decode
	regfile regfile_i (
		.clk(clk), .arst_n(arst_n),
		.wr_en(wb_valid), .wr_addr(wb_rd), .wr_data(wb_data),
		.rd_addr_a(dec_rs1), .rd_addr_b(dec_rs2),
		.rd_data_a(rf_a), .rd_data_b(rf_b)
	);

	// ALU op in execute with a real destination
	assign ex_fwd = ex_valid && (ex_res_sel == rv_core_pkg::RES_ALU) && (ex_rd != '0);

	// Priority execute, then writeback, then regfile
	// wb_valid is never set for x0
	assign op_a = (ex_fwd && ex_rd == dec_rs1)   ? alu_result :
		(wb_valid && wb_rd == dec_rs1) ? wb_data : rf_a;
	assign op_b = dec_use_imm                    ? dec_imm :
		(ex_fwd && ex_rd == dec_rs2)   ? alu_result :
		(wb_valid && wb_rd == dec_rs2) ? wb_data : rf_b;

	assign issue = instr_valid && !div_busy && !dec_illegal;	// Dropped strobes vanish here

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			ex_valid <= 1'b0;
		else
			ex_valid <= issue;
	end

	// ID/EX payload
	always_ff @(posedge clk) begin
		if (issue) begin
			ex_res_sel <= dec_res_sel;
			ex_alu_op  <= dec_alu_op;
			ex_div_op  <= dec_div_op;
			ex_rd      <= dec_writes_rd ? dec_rd : '0;
			ex_op_a    <= op_a;
			ex_op_b    <= op_b;
		end
	end

	assign div_start = ex_valid && (ex_res_sel == rv_core_pkg::RES_DIV);

	// Issuer must hold off while the divider owns the core
	a_no_strobe_when_busy: assert property (@(posedge clk) disable iff (!arst_n)
		!(instr_valid && div_busy))
		else $error("instr_valid strobed while divider busy");

endmodule

`default_nettype wire

/* source/alu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_cfg.svh"

module alu (
	input  rv_core_pkg::alu_op_e    alu_op,
	input  logic [`XLEN-1:0]        op_a,
	input  logic [`XLEN-1:0]        op_b,
	output logic [`XLEN-1:0]        result
);
	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;

	assign shamt = op_b[4:0];	// Low 5 bits only
	assign lt_s  = $signed(op_a) < $signed(op_b);
	assign lt_u  = op_a < op_b;

	always_comb begin
		case (alu_op)
			rv_core_pkg::ALU_ADD:    result = op_a + op_b;
			rv_core_pkg::ALU_SUB:    result = op_a - op_b;
			rv_core_pkg::ALU_SLL:    result = op_a << shamt;
			rv_core_pkg::ALU_SLT:    result = {{(`XLEN-1){1'b0}}, lt_s};
			rv_core_pkg::ALU_SLTU:   result = {{(`XLEN-1){1'b0}}, lt_u};
			rv_core_pkg::ALU_XOR:    result = op_a ^ op_b;
			rv_core_pkg::ALU_SRL:    result = op_a >> shamt;
			// Arithmetic shift keeps the sign bit
			rv_core_pkg::ALU_SRA:    result = $unsigned($signed(op_a) >>> shamt);
			rv_core_pkg::ALU_OR:     result = op_a | op_b;
			rv_core_pkg::ALU_AND:    result = op_a & op_b;
			rv_core_pkg::ALU_PASS_B: result = op_b;	// LUI
			default:                 result = '0;
		endcase
	end

endmodule

`default_nettype wire

/* source/divider.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_cfg.svh"

module divider (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    start,
	input  rv_core_pkg::div_op_e    div_op,
	input  logic [`XLEN-1:0]        op_a,
	input  logic [`XLEN-1:0]        op_b,
	input  logic [`REG_AW-1:0]      rd_in,
	output logic                    busy,
	output logic                    done,
	output logic [`XLEN-1:0]        result,
	output logic [`REG_AW-1:0]      rd_out
);
	localparam int CW = $clog2(`DIV_STEPS);

	logic             running;
	logic [CW-1:0]    cnt;			// Steps still to go
	logic [`XLEN-1:0] rem_q, quo_q, dvsr_q;
	logic             neg_q, neg_r, is_rem, by_zero;
	logic             signed_op, a_neg, b_neg;
	logic [`XLEN-1:0] a_mag, b_mag;

	// One restoring step, shifts a dividend bit into the remainder
	function automatic logic [2*`XLEN-1:0] div_step(input logic [`XLEN-1:0] r,
		input logic [`XLEN-1:0] q, input logic [`XLEN-1:0] d);
		logic [`XLEN:0] shifted;
		logic [`XLEN:0] diff;
		shifted = {r, q[`XLEN-1]};
		diff    = shifted - {1'b0, d};
		if (!diff[`XLEN])
			return {diff[`XLEN-1:0], q[`XLEN-2:0], 1'b1};
		return {shifted[`XLEN-1:0], q[`XLEN-2:0], 1'b0};
	endfunction

	assign signed_op = (div_op == rv_core_pkg::DIV_DIV) || (div_op == rv_core_pkg::DIV_REM);
	assign a_neg     = signed_op && op_a[`XLEN-1];
	assign b_neg     = signed_op && op_b[`XLEN-1];
	assign a_mag     = a_neg ? -op_a : op_a;
	assign b_mag     = b_neg ? -op_b : op_b;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			running <= 1'b0;
			cnt     <= '0;
		end else if (start) begin
			running <= 1'b1;
			cnt     <= CW'(`DIV_STEPS - 1);	// First step taken at load
		end else if (running) begin
			if (cnt == '0)
				running <= 1'b0;
			else
				cnt <= cnt - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			{rem_q, quo_q} <= div_step('0, a_mag, b_mag);
			dvsr_q  <= b_mag;
			neg_q   <= a_neg ^ b_neg;
			neg_r   <= a_neg;			// Remainder follows dividend sign
			is_rem  <= (div_op == rv_core_pkg::DIV_REM) || (div_op == rv_core_pkg::DIV_REMU);
			by_zero <= (op_b == '0);
			rd_out  <= rd_in;
		end else if (running && cnt != '0) begin
			{rem_q, quo_q} <= div_step(rem_q, quo_q, dvsr_q);
		end
	end

	assign done = running && (cnt == '0);
	assign busy = running || start;		// Covers the cycle start sits in execute

	// Divide by zero gives all ones, remainder falls out as the dividend
	// MIN / -1 needs nothing extra since |MIN| reads back as MIN
	assign result = is_rem  ? (neg_r ? -rem_q : rem_q) :
		by_zero ? '1 : (neg_q ? -quo_q : quo_q);

	a_start_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
		start |-> !running)
		else $error("divide started while divider running");

endmodule

`default_nettype wire

/* source/writeback_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_cfg.svh"

module writeback_stage (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    ex_valid,
	input  rv_core_pkg::res_sel_e   ex_res_sel,
	input  logic [`REG_AW-1:0]      ex_rd,
	input  logic [`XLEN-1:0]        alu_result,
	input  logic                    div_done,
	input  logic [`XLEN-1:0]        div_result,
	input  logic [`REG_AW-1:0]      div_rd,
	output logic                    wb_valid,
	output logic [`REG_AW-1:0]      wb_rd,
	output logic [`XLEN-1:0]        wb_data
);
	logic               take_alu;
	logic               take;
	logic [`REG_AW-1:0] sel_rd;

	assign take_alu = ex_valid && (ex_res_sel == rv_core_pkg::RES_ALU);
	assign take     = take_alu || div_done;
	assign sel_rd   = div_done ? div_rd : ex_rd;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			wb_valid <= 1'b0;
		else
			wb_valid <= take && (sel_rd != '0);	// x0 results retire silently
	end

	always_ff @(posedge clk) begin
		if (take) begin
			wb_rd   <= sel_rd;
			wb_data <= div_done ? div_result : alu_result;
		end
	end

	// Busy hold-off keeps the two units apart
	a_one_source: assert property (@(posedge clk) disable iff (!arst_n)
		!(take_alu && div_done))
		else $error("ALU and divider results in the same cycle");

endmodule

`default_nettype wire

/* source/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_cfg.svh"

module rv_core (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  instr_valid,
	input  logic [`XLEN-1:0]      instr,
	output logic                  busy,
	output logic                  wb_valid,
	output logic [`REG_AW-1:0]    wb_rd,
	output logic [`XLEN-1:0]      wb_data
);
	logic                  ex_valid;
	rv_core_pkg::res_sel_e ex_res_sel;
	rv_core_pkg::alu_op_e  ex_alu_op;
	rv_core_pkg::div_op_e  ex_div_op;
	logic [`REG_AW-1:0]    ex_rd;
	logic [`XLEN-1:0]      ex_op_a, ex_op_b;
	logic                  div_start;
	logic [`XLEN-1:0]      alu_result;
	logic                  div_done;		// One cycle, result valid
	logic [`XLEN-1:0]      div_result;
	logic [`REG_AW-1:0]    div_rd;

	// Writeback outputs loop back for regfile write and late forwarding
	issue_stage issue_i (
		.clk(clk), .arst_n(arst_n), .instr_valid(instr_valid), .instr(instr),
		.div_busy(busy), .alu_result(alu_result),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
		.ex_valid(ex_valid), .ex_res_sel(ex_res_sel), .ex_alu_op(ex_alu_op),
		.ex_div_op(ex_div_op), .ex_rd(ex_rd), .ex_op_a(ex_op_a), .ex_op_b(ex_op_b),
		.div_start(div_start)
	);

	alu alu_i (.alu_op(ex_alu_op), .op_a(ex_op_a), .op_b(ex_op_b), .result(alu_result));

	// Runs beside the ALU on the same operands
	divider divider_i (
		.clk(clk), .arst_n(arst_n), .start(div_start), .div_op(ex_div_op),
		.op_a(ex_op_a), .op_b(ex_op_b), .rd_in(ex_rd),
		.busy(busy), .done(div_done), .result(div_result), .rd_out(div_rd)
	);

	writeback_stage writeback_i (
		.clk(clk), .arst_n(arst_n), .ex_valid(ex_valid), .ex_res_sel(ex_res_sel),
		.ex_rd(ex_rd), .alu_result(alu_result),
		.div_done(div_done), .div_result(div_result), .div_rd(div_rd),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
	);

endmodule

`default_nettype wire

/* tests/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_cfg.svh"

module tb_rv_core;

	localparam int CLK_PERIOD  = 4;
	localparam int N_ALU       = 40;
	localparam int N_DIV       = 21;			// Test 4 plus the x0 divide of test 5
	localparam int DRAIN_LIMIT = `DIV_STEPS + 8;
	localparam int BUDGET_CYC  = 2 * (16 + 100 + N_ALU * 4 + 4 * 40 +
		N_DIV * (`DIV_STEPS + 12) + 150);

	logic        clk;
	logic        arst_n;
	logic        instr_valid;
	logic [31:0] instr;
	logic        busy;
	logic        wb_valid;
	logic [4:0]  wb_rd;
	logic [31:0] wb_data;

	logic [31:0] lfsr = 32'h8268;
	logic [31:0] shadow [32];				// Architectural state as the model sees it
	logic [4:0]  exp_rd_q [$];
	logic [31:0] exp_data_q [$];
	int          exp_cyc_q [$];
	int          cyc = 0;
	int          errors = 0;
	string       test_name = "reset";

	rv_core dut_i (
		.clk(clk), .arst_n(arst_n), .instr_valid(instr_valid), .instr(instr),
		.busy(busy), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
	function automatic logic [31:0] rand_word(input int nbits);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, 7'b0110111};
	endfunction

	// RV32I integer semantics where alt selects SUB or SRA
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: return (a < b) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b101: begin
				if (alt)
					return $signed(a) >>> b[4:0];	// Sign fills from the left
				return a >> b[4:0];
			end
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	// DIV DIVU REM REMU with the RISC-V corner cases
	function automatic logic [31:0] div_ref(input logic [1:0] op, input logic [31:0] a,
		input logic [31:0] b);
		if (b == '0)
			return op[1] ? a : 32'hffff_ffff;
		if (!op[0] && a == 32'h8000_0000 && b == 32'hffff_ffff)
			return op[1] ? 32'd0 : a;		// Signed overflow
		case (op)
			2'b00: return $signed(a) / $signed(b);
			2'b01: return a / b;
			2'b10: return $signed(a) % $signed(b);
			default: return a % b;
		endcase
	endfunction

	// Predicts one retirement and updates the shadow registers
	task automatic predict(input logic [31:0] ins, output logic wr, output logic is_div,
		output logic [31:0] res);
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [31:0] a;
		logic [31:0] b;
		logic        legal;
		f3     = ins[14:12];
		f7     = ins[31:25];
		a      = shadow[ins[19:15]];
		b      = shadow[ins[24:20]];
		legal  = 1'b0;
		is_div = 1'b0;
		res    = '0;
		if (ins[6:0] == 7'b0110011 && f7 == 7'b0000001) begin
			legal  = f3[2];				// MUL group has no unit
			is_div = 1'b1;
			res    = div_ref(f3[1:0], a, b);
		end else if (ins[6:0] == 7'b0110011) begin
			legal = (f7 == 7'b0) || (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101));
			res   = alu_ref(f3, f7[5], a, b);
		end else if (ins[6:0] == 7'b0010011) begin
			legal = !(f3 == 3'b001 && f7 != 7'b0) &&
				!(f3 == 3'b101 && f7 != 7'b0 && f7 != 7'b0100000);
			res   = alu_ref(f3, f3 == 3'b101 && f7[5], a, {{20{ins[31]}}, ins[31:20]});
		end else if (ins[6:0] == 7'b0110111) begin
			legal = 1'b1;
			res   = {ins[31:12], 12'b0};
		end
		wr = legal && (ins[11:7] != 5'd0);
		if (wr)
			shadow[ins[11:7]] = res;
	endtask

	task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("[ERROR] %s %s: expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic step(input logic v, input logic [31:0] ins);
		@(posedge clk);
		#1;
		instr_valid = v;
		instr       = ins;
	endtask

	// Strobe one instruction and queue what should retire
	task automatic issue(input logic [31:0] ins);
		logic        wr;
		logic        is_div;
		logic [31:0] res;
		step(1'b1, ins);
		predict(ins, wr, is_div, res);
		if (wr) begin
			exp_rd_q.push_back(ins[11:7]);
			exp_data_q.push_back(res);
			exp_cyc_q.push_back(cyc + (is_div ? `DIV_STEPS + 2 : 2));
		end
	endtask

	task automatic drain();
		int n;
		step(1'b0, '0);
		n = 0;
		while (exp_rd_q.size() != 0 && n < DRAIN_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (exp_rd_q.size() != 0) begin
			$display("Timed out in test %s: %0d results never showed up on wb_valid",
				test_name, exp_rd_q.size());
			errors++;
			exp_rd_q.delete();
			exp_data_q.delete();
			exp_cyc_q.delete();
		end
		repeat (3) @(negedge clk);		// Room for a stray wb_valid
	endtask

	// lui plus addi with the upper part rounded for the sign of the low 12 bits
	task automatic load_reg(input logic [4:0] r, input logic [31:0] v);
		logic [31:0] hi;
		hi = (v + 32'h800) >> 12;
		issue(enc_lui(hi[19:0], r));
		issue(enc_i(v[11:0], r, 3'b000, r));
	endtask

	task automatic run_div(input logic [1:0] op, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [4:0] rs2);
		issue(enc_r(7'b0000001, rs2, rs1, {1'b1, op}, rd));
		step(1'b0, '0);
		repeat (`DIV_STEPS + 1) begin
			@(negedge clk);
			check_eq("busy", 32'd1, 32'(busy));
		end
		@(negedge clk);
		check_eq("busy", 32'd0, 32'(busy));	// Issue allowed again in the result cycle
	endtask

	// Scoreboard checks retirement order, data and latency
	always @(negedge clk) begin
		if (arst_n && wb_valid) begin
			if (exp_rd_q.size() == 0) begin
				$display("Unexpected result in test %s: x%0d written with 0x%08h",
					test_name, wb_rd, wb_data);
				errors++;
			end else begin
				check_eq("wb_rd", 32'(exp_rd_q.pop_front()), 32'(wb_rd));
				check_eq("wb_data", exp_data_q.pop_front(), wb_data);
				check_eq("latency", exp_cyc_q.pop_front(), cyc);
			end
		end
	end

	task automatic reset_regs();
		test_name = "reset_regs";
		check_eq("wb_valid", 32'd0, 32'(wb_valid));
		check_eq("busy", 32'd0, 32'(busy));
		for (int r = 1; r < 32; r++)
			issue(enc_i(12'(rand_word(12)), 5'd0, 3'b000, 5'(r)));
		issue(enc_i(12'h5a5, 5'd0, 3'b000, 5'd0));	// Dropped write to x0
		issue(enc_r(7'b0, 5'd0, 5'd0, 3'b000, 5'd1));
		for (int r = 2; r < 32; r++)
			issue(enc_r(7'b0, 5'd0, 5'(r), 3'b110, 5'(r)));
		drain();
	endtask

	task automatic alu_random();
		logic [2:0]  f3;
		logic [4:0]  rd;
		logic [6:0]  f7;
		logic [31:0] ins;
		test_name = "alu_random";
		for (int i = 0; i < N_ALU; i++) begin
			f3 = 3'(rand_word(3));
			rd = 5'(rand_word(5));
			if (rd == 5'd0)
				rd = 5'd1;
			f7 = (rand_word(1) != 0 && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0;
			case (2'(rand_word(2)))
				2'd2: begin
					if (f3 == 3'b001 || f3 == 3'b101)
						ins = enc_i({f7, 5'(rand_word(5))}, 5'(rand_word(5)), f3, rd);
					else
						ins = enc_i(12'(rand_word(12)), 5'(rand_word(5)), f3, rd);
				end
				2'd3: ins = enc_lui(20'(rand_word(20)), rd);
				default: ins = enc_r(f7, 5'(rand_word(5)), 5'(rand_word(5)), f3, rd);
			endcase
			issue(ins);
			step(1'b0, '0);			// Two idle slots keep operands on the regfile path
			step(1'b0, '0);
		end
		drain();
	endtask

	task automatic forward_chain();
		test_name = "forward_chain";
		for (int i = 0; i < 4; i++) begin
			load_reg(5'd1, rand_word(32));
			load_reg(5'd2, rand_word(32));
			issue(enc_r(7'b0, 5'd2, 5'd1, 3'b000, 5'd3));		// add with x2 in both ex and wb
			issue(enc_r(7'b0100000, 5'd1, 5'd3, 3'b000, 5'd4));	// sub
			issue(enc_r(7'b0, 5'd3, 5'd4, 3'b100, 5'd5));
			issue(enc_r(7'b0, 5'd2, 5'd5, 3'b001, 5'd6));
			issue(enc_r(7'b0, 5'd4, 5'd6, 3'b010, 5'd7));		// slt
			issue(enc_r(7'b0, 5'd7, 5'd6, 3'b110, 5'd8));		// or with x6 from wb
			issue(enc_i({7'b0100000, 5'd7}, 5'd8, 3'b101, 5'd9));	// srai
			issue(enc_r(7'b0, 5'd9, 5'd9, 3'b000, 5'd10));
		end
		drain();
	endtask

	task automatic divide();
		logic [31:0] b;
		test_name = "divide";
		for (int i = 0; i < 3; i++) begin
			b = rand_word(32);
			b = b >> 5'(rand_word(5));		// Spread the quotient sizes
			load_reg(5'd1, rand_word(32));
			load_reg(5'd2, b);
			for (int op = 0; op < 4; op++)
				run_div(2'(op), 5'(3 + op), 5'd1, 5'd2);
		end
		load_reg(5'd1, rand_word(32));
		load_reg(5'd2, 32'd0);
		for (int op = 0; op < 4; op++)
			run_div(2'(op), 5'(3 + op), 5'd1, 5'd2);
		load_reg(5'd1, 32'h8000_0000);
		load_reg(5'd2, 32'hffff_ffff);
		for (int op = 0; op < 4; op++)
			run_div(2'(op), 5'(3 + op), 5'd1, 5'd2);
		drain();
	endtask

	task automatic x0_and_illegal();
		test_name = "x0_and_illegal";
		load_reg(5'd10, rand_word(32));
		load_reg(5'd11, rand_word(32));
		issue(enc_r(7'b0, 5'd11, 5'd10, 3'b000, 5'd0));
		issue(enc_r(7'b0, 5'd0, 5'd0, 3'b000, 5'd12));		// Must read zero
		issue(enc_i(12'h005, 5'd10, 3'b000, 5'd0));
		issue(enc_r(7'b0, 5'd10, 5'd0, 3'b110, 5'd13));
		issue({12'h010, 5'd11, 3'b010, 5'd10, 7'b0000011});	// Load
		issue({7'b0, 5'd11, 5'd10, 3'b000, 5'b01000, 7'b1100011});	// Branch
		issue(enc_r(7'b0000001, 5'd11, 5'd10, 3'b000, 5'd10));	// mul
		issue(enc_r(7'b0100000, 5'd11, 5'd10, 3'b001, 5'd11));
		issue(enc_i({7'b0100000, 5'd3}, 5'd10, 3'b001, 5'd11));	// Bad slli
		drain();
		run_div(2'b00, 5'd0, 5'd10, 5'd11);
		issue(enc_r(7'b0, 5'd0, 5'd10, 3'b110, 5'd14));
		issue(enc_r(7'b0, 5'd0, 5'd11, 3'b110, 5'd15));
		drain();
	endtask

	initial begin
		#(BUDGET_CYC * CLK_PERIOD);
		$display("Watchdog expired, tests did not finish within %0d cycles", BUDGET_CYC);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		clk         = 1'b0;
		arst_n      = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		for (int r = 0; r < 32; r++)
			shadow[r] = '0;
		repeat (16) @(posedge clk);
		#1;
		arst_n = 1'b1;
		reset_regs();
		alu_random();
		forward_chain();
		divide();
		x0_and_illegal();
		$display("Checks finished with %0d errors", errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+source
source/rv_core_pkg.sv
source/instr_decoder.sv
source/regfile.sv
source/issue_stage.sv
source/alu.sv
source/divider.sv
source/writeback_stage.sv
source/rv_core.sv
tests/tb_rv_core.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_rv_core -o sim_tb_rv_core

output=$(./obj_dir/sim_tb_rv_core 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "SIMULATION PASSED"; then
	exit 0
fi
exit 1
